/* logic/coco_glue_pkg.sv */
/*
 * CoCo2 / Dragon glue package
 * Shared widths, timing constants, register map and the structs
 * passed between the register bank, sequencer, slicer and router
 */
`default_nettype none

package coco_glue_pkg;

	////////////////////
	// Widths and constants
	localparam int ADC_W      = 12;                 // ADC sample and core sound
	localparam int AUDIO_W    = 16;                 // Mixed audio out
	localparam int AVG_DEPTH  = 512;                // Samples in running average
	localparam int AVG_SHIFT  = 9;                  // log2(AVG_DEPTH)
	localparam int SUM_W      = ADC_W + AVG_SHIFT;  // Running total
	localparam int SLICE_BAND = 100;                // Hysteresis in ADC counts
	localparam int RESET_HOLD = 15;                 // Core reset cycles after a change
	localparam int HOLD_W     = $clog2(RESET_HOLD + 1);
	localparam int JOY_W      = 32;                 // Digital joystick word
	localparam int AXIS_W     = 8;                  // One analog axis
	localparam int AXIS_BIAS  = 128;                // Signed axis to unsigned centre
	localparam int WB_DW      = 32;                 // Wishbone data bus

	// Word addresses
	localparam logic REG_CFG  = 1'b0;
	localparam logic REG_STAT = 1'b1;

	////////////////////
	// Machine select
	// Code 3 is treated as a plain Dragon
	typedef enum logic [1:0]
	{
		COCO2    = 2'd0,
		DRAGON32 = 2'd1,
		DRAGON64 = 2'd2
	} machine_t;

	// Configuration word, MSB first
	typedef struct packed
	{
		logic     soft_reset;     // [7]
		machine_t machine;        // [6:5]
		logic     disk_cart;      // [4] Disk ROM instead of cartridge
		logic     hard_toggle;    // [3] Any edge forces hard reset
		logic     tape_from_adc;  // [2]
		logic     tape_monitor;   // [1] Tape bit into audio
		logic     joy_swap;       // [0]
	} cfg_t;

	localparam int CFG_W = $bits(cfg_t);

	////////////////////
	// Wishbone classic
	typedef struct packed
	{
		logic             cyc;
		logic             stb;
		logic             we;
		logic             adr;    // Word address
		logic [WB_DW-1:0] dat;
		logic [3:0]       sel;
	} wb_req_t;

	typedef struct packed
	{
		logic             ack;
		logic [WB_DW-1:0] dat;
	} wb_rsp_t;

	// Mode flags to the core
	typedef struct packed
	{
		logic is_dragon;
		logic is_dragon64;
		logic disk_cart;
	} mode_t;

	// Analog stick, one byte per axis
	typedef struct packed
	{
		logic [AXIS_W-1:0] x;
		logic [AXIS_W-1:0] y;
	} ajoy_t;

endpackage

`default_nettype wire

/* logic/wb_config_regs.sv */
/*
 * Configuration register bank
 * Wishbone classic slave with one read/write config word and a
 * read-only status word carrying the tape slicer bit and core reset
 */
`default_nettype none

module wb_config_regs
(
	input  wire                   i_clk_sys,
	input  wire                   i_arst_n,
	input  coco_glue_pkg::wb_req_t i_wb,
	output coco_glue_pkg::wb_rsp_t o_wb,
	input  wire                   i_tape_bit,
	input  wire                   i_core_reset,
	output coco_glue_pkg::cfg_t   o_cfg
);

	import coco_glue_pkg::*;

	logic             req;      // New request this cycle
	logic             ack_q;
	logic [WB_DW-1:0] rdata_q;
	cfg_t             cfg_q;

	// Block the cycle after ack so the master can drop stb
	assign req = i_wb.cyc & i_wb.stb & ~ack_q;

	////////////////////
	// Ack and config register
	always_ff @(posedge i_clk_sys or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			ack_q <= 1'b0;
			cfg_q <= '0;
		end
		else
		begin
			ack_q <= req;                     // Single cycle pulse
			if (req && i_wb.we && (i_wb.adr == REG_CFG) && i_wb.sel[0])
				cfg_q <= cfg_t'(i_wb.dat[CFG_W-1:0]);  // Lands with the ack
			// Writes to status are dropped
		end
	end

	////////////////////
	// Read data mux
	always_ff @(posedge i_clk_sys)
	begin
		if (req)
		begin
			case (i_wb.adr)
				REG_CFG:  rdata_q <= {{(WB_DW - CFG_W){1'b0}}, cfg_q};
				default:  rdata_q <= {{(WB_DW - 2){1'b0}}, i_core_reset, i_tape_bit};
			endcase
		end
	end

	assign o_wb.ack = ack_q;
	assign o_wb.dat = rdata_q;
	assign o_cfg    = cfg_q;

endmodule

`default_nettype wire

/* logic/machine_reset_seq.sv */
/*
 * Machine select and reset sequencer
 * Decodes the machine field into core mode flags and restarts the core
 * whenever the machine, cartridge mode or hard reset toggle changes
 */
`default_nettype none

module machine_reset_seq
(
	input  wire                 i_clk_sys,
	input  wire                 i_arst_n,
	input  coco_glue_pkg::cfg_t  i_cfg,
	output coco_glue_pkg::mode_t o_mode,
	output logic                o_core_reset,
	output logic                o_hard_reset
);

	import coco_glue_pkg::*;

	machine_t          machine_q;   // Last seen machine
	logic              disk_q;      // Last seen cart mode
	logic              toggle_q;    // Last seen hard reset toggle
	logic              mode_change;
	logic [HOLD_W-1:0] hold_cnt;    // Core reset down-counter
	logic              hard_arm;    // First step of hard reset

	// Any watched field differs from its copy
	assign mode_change = (i_cfg.machine != machine_q) |
		(i_cfg.disk_cart != disk_q) |
		(i_cfg.hard_toggle != toggle_q);

	////////////////////
	// Change tracking and hold counter
	always_ff @(posedge i_clk_sys or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			machine_q    <= COCO2;
			disk_q       <= 1'b0;
			toggle_q     <= 1'b0;
			hold_cnt     <= '0;
			hard_arm     <= 1'b0;
			o_hard_reset <= 1'b0;
		end
		else
		begin
			machine_q <= i_cfg.machine;
			disk_q    <= i_cfg.disk_cart;
			toggle_q  <= i_cfg.hard_toggle;

			// Reload on every change, even mid-hold
			if (mode_change)
				hold_cnt <= HOLD_W'(RESET_HOLD);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;

			// Two steps, pulse lands two cycles after the change
			hard_arm     <= mode_change;
			o_hard_reset <= hard_arm;
		end
	end

	////////////////////
	// Mode decode from the registered copies
	always_comb
	begin
		o_mode.is_dragon   = (machine_q != COCO2);     // Code 3 too
		o_mode.is_dragon64 = (machine_q == DRAGON64);
		o_mode.disk_cart   = disk_q;
	end

	// Hold count or soft reset from the host
	assign o_core_reset = (hold_cnt != '0) | i_cfg.soft_reset;

endmodule

`default_nettype wire

/* logic/adc_tape_slicer.sv */
/*
 * Cassette ADC slicer
 * Tracks a running average over the last 512 samples and slices each
 * new sample against it with a hysteresis band to recover the tape bit
 */
`default_nettype none

module adc_tape_slicer
(
	input  wire                            i_clk_sys,
	input  wire                            i_arst_n,
	input  wire                            i_adc_valid,
	input  wire [coco_glue_pkg::ADC_W-1:0] i_adc_sample,
	output logic                           o_tape_bit
);

	import coco_glue_pkg::*;

	logic [ADC_W-1:0]        win_mem [AVG_DEPTH];  // Sample window
	logic [AVG_SHIFT-1:0]    wr_ptr;               // Oldest entry, next write
	logic                    wrapped;              // Window filled once
	logic                    stage_vld;            // Second pipe stage
	logic [ADC_W-1:0]        sample_q;
	logic [ADC_W-1:0]        oldest_q;
	logic [ADC_W-1:0]        oldest;
	logic [SUM_W-1:0]        total;                // Sum of window
	logic [ADC_W-1:0]        avg;
	logic signed [ADC_W+1:0] sample_s;             // Two guard bits
	logic signed [ADC_W+1:0] lo_s;
	logic signed [ADC_W+1:0] hi_s;

	////////////////////
	// Stage 1 latches sample and reads oldest
	always_ff @(posedge i_clk_sys)
	begin
		if (i_adc_valid)
		begin
			sample_q <= i_adc_sample;
			oldest_q <= win_mem[wr_ptr];
		end
		if (stage_vld)
			win_mem[wr_ptr] <= sample_q;   // Overwrite the oldest
	end

	// Unwritten slots read as zero until the first wrap
	assign oldest = wrapped ? oldest_q : '0;

	// Average of the window before this sample joins
	assign avg      = total[SUM_W-1:AVG_SHIFT];
	assign sample_s = $signed({2'b00, sample_q});
	assign lo_s     = $signed({2'b00, avg}) - (ADC_W + 2)'(SLICE_BAND);
	assign hi_s     = $signed({2'b00, avg}) + (ADC_W + 2)'(SLICE_BAND);

	////////////////////
	// Stage 2 updates sum, pointer and bit
	always_ff @(posedge i_clk_sys or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			stage_vld  <= 1'b0;
			wr_ptr     <= '0;
			wrapped    <= 1'b0;
			total      <= '0;
			o_tape_bit <= 1'b0;
		end
		else
		begin
			stage_vld <= i_adc_valid;
			if (stage_vld)
			begin
				total  <= total - SUM_W'(oldest) + SUM_W'(sample_q);
				wr_ptr <= wr_ptr + 1'b1;
				if (&wr_ptr)
					wrapped <= 1'b1;

				// Polarity inverted as on the real machine
				if (sample_s < lo_s)
					o_tape_bit <= 1'b1;
				else if (sample_s > hi_s)
					o_tape_bit <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/peripheral_router.sv */
/*
 * Peripheral router
 * Picks the cassette source, builds the 16-bit audio mix and routes
 * the joysticks with optional swap and analog recentering
 */
`default_nettype none

module peripheral_router
(
	input  coco_glue_pkg::cfg_t              i_cfg,
	input  wire                              i_adc_bit,
	input  wire                              i_player_bit,
	input  wire                              i_core_sndout,
	input  wire  [coco_glue_pkg::ADC_W-1:0]  i_core_sound,
	input  wire  [coco_glue_pkg::JOY_W-1:0]  i_joy1,
	input  wire  [coco_glue_pkg::JOY_W-1:0]  i_joy2,
	input  coco_glue_pkg::ajoy_t             i_ajoy1,
	input  coco_glue_pkg::ajoy_t             i_ajoy2,
	output logic                             o_core_tape,
	output logic [coco_glue_pkg::AUDIO_W-1:0] o_audio,
	output logic [coco_glue_pkg::JOY_W-1:0]  o_joy1,
	output logic [coco_glue_pkg::JOY_W-1:0]  o_joy2,
	output coco_glue_pkg::ajoy_t             o_ajoy1,
	output coco_glue_pkg::ajoy_t             o_ajoy2
);

	import coco_glue_pkg::*;

	ajoy_t ajoy1_c;   // Centred sticks
	ajoy_t ajoy2_c;

	// Signed axis to unsigned, wraps at 256
	function automatic ajoy_t center_axes(input ajoy_t a);
		ajoy_t c;
		c.x = a.x + AXIS_W'(AXIS_BIAS);
		c.y = a.y + AXIS_W'(AXIS_BIAS);
		return c;
	endfunction

	////////////////////
	// Tape and audio
	assign o_core_tape = i_cfg.tape_from_adc ? i_adc_bit : i_player_bit;

	// 1-bit sound loudest, tape monitor low in the mix
	assign o_audio = {i_core_sndout,
		i_core_sound[11:6],
		i_core_sound[5] ^ (i_cfg.tape_monitor & o_core_tape),
		i_core_sound[4:0],
		3'b000};

	////////////////////
	// Joysticks
	assign ajoy1_c = center_axes(i_ajoy1);
	assign ajoy2_c = center_axes(i_ajoy2);

	assign o_joy1  = i_cfg.joy_swap ? i_joy2 : i_joy1;
	assign o_joy2  = i_cfg.joy_swap ? i_joy1 : i_joy2;
	assign o_ajoy1 = i_cfg.joy_swap ? ajoy2_c : ajoy1_c;
	assign o_ajoy2 = i_cfg.joy_swap ? ajoy1_c : ajoy2_c;

endmodule

`default_nettype wire

/* logic/coco_glue.sv */
/*
 * CoCo2 / Dragon glue top level
 * Joins the config register bank, machine reset sequencer, cassette
 * ADC slicer and peripheral router around the external core
 */
`default_nettype none

module coco_glue
(
	input  wire                               clk_sys,
	input  wire                               i_arst_n,
	// Host bus
	input  coco_glue_pkg::wb_req_t            i_wb,
	output coco_glue_pkg::wb_rsp_t            o_wb,
	// Cassette ADC
	input  wire                               i_adc_valid,
	input  wire  [coco_glue_pkg::ADC_W-1:0]   i_adc_sample,
	// From the core
	input  wire                               i_player_bit,
	input  wire                               i_core_sndout,
	input  wire  [coco_glue_pkg::ADC_W-1:0]   i_core_sound,
	// Controllers
	input  wire  [coco_glue_pkg::JOY_W-1:0]   i_joy1,
	input  wire  [coco_glue_pkg::JOY_W-1:0]   i_joy2,
	input  coco_glue_pkg::ajoy_t              i_ajoy1,
	input  coco_glue_pkg::ajoy_t              i_ajoy2,
	// To the core
	output coco_glue_pkg::mode_t              o_mode,
	output logic                              o_core_reset,
	output logic                              o_hard_reset,
	output logic                              o_core_tape,
	output logic [coco_glue_pkg::AUDIO_W-1:0] o_audio,
	output logic [coco_glue_pkg::JOY_W-1:0]   o_joy1,
	output logic [coco_glue_pkg::JOY_W-1:0]   o_joy2,
	output coco_glue_pkg::ajoy_t              o_ajoy1,
	output coco_glue_pkg::ajoy_t              o_ajoy2
);

	import coco_glue_pkg::*;

	cfg_t cfg;          // Live configuration
	logic slicer_bit;   // Sliced cassette bit

	////////////////////
	// Register bank
	wb_config_regs u_regs
	(
		.i_clk_sys    (clk_sys),
		.i_arst_n     (i_arst_n),
		.i_wb         (i_wb),
		.o_wb         (o_wb),
		.i_tape_bit   (slicer_bit),
		.i_core_reset (o_core_reset),   // Read back in status
		.o_cfg        (cfg)
	);

	// Machine decode and reset
	machine_reset_seq u_seq
	(
		.i_clk_sys    (clk_sys),
		.i_arst_n     (i_arst_n),
		.i_cfg        (cfg),
		.o_mode       (o_mode),
		.o_core_reset (o_core_reset),
		.o_hard_reset (o_hard_reset)
	);

	// Cassette slicer
	adc_tape_slicer u_slicer
	(
		.i_clk_sys    (clk_sys),
		.i_arst_n     (i_arst_n),
		.i_adc_valid  (i_adc_valid),
		.i_adc_sample (i_adc_sample),
		.o_tape_bit   (slicer_bit)
	);

	////////////////////
	// Tape, audio and joysticks
	peripheral_router u_router
	(
		.i_cfg         (cfg),
		.i_adc_bit     (slicer_bit),
		.i_player_bit  (i_player_bit),
		.i_core_sndout (i_core_sndout),
		.i_core_sound  (i_core_sound),
		.i_joy1        (i_joy1),
		.i_joy2        (i_joy2),
		.i_ajoy1       (i_ajoy1),
		.i_ajoy2       (i_ajoy2),
		.o_core_tape   (o_core_tape),
		.o_audio       (o_audio),
		.o_joy1        (o_joy1),
		.o_joy2        (o_joy2),
		.o_ajoy1       (o_ajoy1),
		.o_ajoy2       (o_ajoy2)
	);

endmodule

`default_nettype wire

/* sim/coco_glue_chk.sv */
/*
 * Pulse checks for the glue logic
 * Bound to the Wishbone ack and to the hard reset pulse
 */
`default_nettype none

module coco_glue_chk
(
	input wire i_clk_sys,
	input wire i_arst_n,
	input wire i_trig,     // stb, or the core reset hold
	input wire i_pulse     // ack, or the hard reset pulse
);

	// Never high two cycles running
	property p_single;
		@(posedge i_clk_sys) disable iff (!i_arst_n)
		i_pulse |=> !i_pulse;
	endproperty

	// Pulse only after its trigger
	property p_after_trig;
		@(posedge i_clk_sys) disable iff (!i_arst_n)
		i_pulse |-> $past(i_trig);
	endproperty

	a_single: assert property (p_single)
		else $error("pulse stayed high for two cycles");
	a_after_trig: assert property (p_after_trig)
		else $error("pulse seen without its trigger one cycle earlier");

endmodule

////////////////////
// Ack follows stb
bind wb_config_regs coco_glue_chk u_wb_chk
(
	.i_clk_sys (i_clk_sys),
	.i_arst_n  (i_arst_n),
	.i_trig    (i_wb.stb),
	.i_pulse   (o_wb.ack)
);

// Hard reset pulse lands inside the core reset hold
bind machine_reset_seq coco_glue_chk u_seq_chk
(
	.i_clk_sys (i_clk_sys),
	.i_arst_n  (i_arst_n),
	.i_trig    (o_core_reset),
	.i_pulse   (o_hard_reset)
);

`default_nettype wire

/* sim/coco_glue_tb.sv */
/*
 * Testbench for the CoCo2 / Dragon glue top level
 * Directed tests for the register bank, reset sequencer, tape slicer,
 * audio mix and joystick routing against models of each rule
 */
`default_nettype none

module coco_glue_tb;

	import coco_glue_pkg::*;

	localparam int HALF_PERIOD    = 20;
	localparam int ACK_LIMIT      = 8;      // Cycles to wait for ack
	localparam int N_RANDOM       = 800;    // Random slicer samples
	localparam int N_STEPPED      = 400;    // Stepped slicer samples
	localparam int STAT_EVERY     = 64;     // Status read interval
	localparam int SLICE_CYCLES   = (N_RANDOM + N_STEPPED) * 5;
	localparam int OTHER_CYCLES   = 400;    // Register, machine, audio, joystick
	localparam int TIMEOUT_CYCLES = 2 * (SLICE_CYCLES + OTHER_CYCLES);

	logic               clk_sys;
	logic               arst_n;
	wb_req_t            wb_req;
	wb_rsp_t            wb_rsp;
	logic               adc_valid;
	logic [ADC_W-1:0]   adc_sample;
	logic               player_bit;
	logic               core_sndout;
	logic [ADC_W-1:0]   core_sound;
	logic [JOY_W-1:0]   joy1_in;
	logic [JOY_W-1:0]   joy2_in;
	ajoy_t              ajoy1_in;
	ajoy_t              ajoy2_in;
	mode_t              mode;
	logic               core_reset;
	logic               hard_reset;
	logic               core_tape;
	logic [AUDIO_W-1:0] audio;
	logic [JOY_W-1:0]   joy1_out;
	logic [JOY_W-1:0]   joy2_out;
	ajoy_t              ajoy1_out;
	ajoy_t              ajoy2_out;

	int          errors;
	int          checks;
	int          cycle_cnt;
	logic [31:0] rng_state;
	cfg_t        cfg_now;        // Last value written to REG_CFG

	// Slicer reference, zero-filled window
	logic [ADC_W-1:0]     model_win [AVG_DEPTH];
	logic [AVG_SHIFT-1:0] model_ptr;
	int                   model_total;
	logic                 model_bit;

	coco_glue UUT
	(
		.clk_sys      (clk_sys),
		.i_arst_n     (arst_n),
		.i_wb         (wb_req),
		.o_wb         (wb_rsp),
		.i_adc_valid  (adc_valid),
		.i_adc_sample (adc_sample),
		.i_player_bit (player_bit),
		.i_core_sndout(core_sndout),
		.i_core_sound (core_sound),
		.i_joy1       (joy1_in),
		.i_joy2       (joy2_in),
		.i_ajoy1      (ajoy1_in),
		.i_ajoy2      (ajoy2_in),
		.o_mode       (mode),
		.o_core_reset (core_reset),
		.o_hard_reset (hard_reset),
		.o_core_tape  (core_tape),
		.o_audio      (audio),
		.o_joy1       (joy1_out),
		.o_joy2       (joy2_out),
		.o_ajoy1      (ajoy1_out),
		.o_ajoy2      (ajoy2_out)
	);

	always #HALF_PERIOD clk_sys = ~clk_sys;

	// Run limit
	always @(posedge clk_sys)
	begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Error: run stopped after %0d cycles, a test did not finish", cycle_cnt);
			$display("Testbench failed");
			$finish;
		end
	end

	////////////////////
	// Models and stimulus
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);   // xorshift32
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Machine code to core flags, code 3 a plain Dragon
	function automatic mode_t decode_mode(input cfg_t c);
		mode_t      m;
		logic [1:0] code;
		code          = c.machine;
		m.is_dragon   = (code != 2'b00);
		m.is_dragon64 = (code == 2'b10);
		m.disk_cart   = c.disk_cart;
		return m;
	endfunction

	// Sound word under sndout with bit 8 flipped by the tape monitor
	function automatic logic [AUDIO_W-1:0] mix_audio(input cfg_t c, input logic tape,
		input logic snd_bit, input logic [ADC_W-1:0] snd);
		logic [AUDIO_W-1:0] a;
		a = {snd_bit, snd, 3'b000};
		if (c.tape_monitor && tape)
			a[8] = ~a[8];
		return a;
	endfunction

	function automatic ajoy_t recenter(input ajoy_t a);
		ajoy_t r;
		r.x = AXIS_W'((int'(a.x) + AXIS_BIAS) % 256);   // Wraps at 256
		r.y = AXIS_W'((int'(a.y) + AXIS_BIAS) % 256);
		return r;
	endfunction

	// Average taken before the sample joins the window
	function automatic void model_slice(input logic [ADC_W-1:0] s);
		int avg;
		avg = model_total >> AVG_SHIFT;
		if (int'(s) < avg - SLICE_BAND)
			model_bit = 1'b1;
		else if (int'(s) > avg + SLICE_BAND)
			model_bit = 1'b0;
		model_total = model_total - int'(model_win[model_ptr]) + int'(s);
		model_win[model_ptr] = s;
		model_ptr = model_ptr + 1'b1;
	endfunction

	////////////////////
	// Compare tasks
	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_cfg(input string name, input cfg_t got, input cfg_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_mode(input string name, input mode_t got, input mode_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_audio(input string name, input logic [AUDIO_W-1:0] got,
		input logic [AUDIO_W-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_joy(input string name, input logic [JOY_W-1:0] got,
		input logic [JOY_W-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_ajoy(input string name, input ajoy_t got, input ajoy_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	////////////////////
	// Wishbone master
	task automatic wb_transfer(input logic we, input logic adr, input logic [WB_DW-1:0] dat,
		input logic [3:0] sel, output logic [WB_DW-1:0] rdat);
		int waited;
		waited = 0;
		@(negedge clk_sys);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = dat;
		wb_req.sel = sel;
		do
		begin
			@(negedge clk_sys);
			waited++;
		end
		while (!wb_rsp.ack && waited < ACK_LIMIT);
		checks++;
		if (!wb_rsp.ack)
		begin
			errors++;
			$display("Error: no ack within %0d cycles at word %0d", ACK_LIMIT, adr);
		end
		else if (waited != 1)
		begin
			errors++;
			$display("Error: ack came %0d cycles after stb instead of 1", waited);
		end
		rdat = wb_rsp.dat;
		wb_req.cyc = 1'b0;     // Idle at least one cycle before the next
		wb_req.stb = 1'b0;
		wb_req.we  = 1'b0;
	endtask

	task automatic reg_write(input logic adr, input logic [WB_DW-1:0] dat, input logic [3:0] sel);
		logic [WB_DW-1:0] unused_rdat;
		wb_transfer(1'b1, adr, dat, sel, unused_rdat);
	endtask

	task automatic reg_read(input logic adr, output logic [WB_DW-1:0] rdat);
		wb_transfer(1'b0, adr, '0, 4'hF, rdat);
	endtask

	// Called right after the write that made the change
	task automatic watch_reset();
		int held;
		int first_hold;
		int pulses;
		int pulse_at;
		held       = 0;
		first_hold = 0;
		pulses     = 0;
		pulse_at   = 0;
		for (int i = 1; i <= RESET_HOLD + 6; i++)
		begin
			@(negedge clk_sys);
			if (core_reset)
			begin
				held++;
				if (first_hold == 0)
					first_hold = i;
			end
			if (hard_reset)
			begin
				pulses++;
				pulse_at = i;
			end
		end
		checks += 2;
		if (held != RESET_HOLD || first_hold != 1)
		begin
			errors++;
			$display("Error: core reset held %0d cycles from cycle %0d, expected %0d from cycle 1",
				held, first_hold, RESET_HOLD);
		end
		if (pulses != 1 || pulse_at != 2)
		begin
			errors++;
			$display("Error: %0d hard reset pulses, last at cycle %0d, expected one at cycle 2",
				pulses, pulse_at);
		end
		check_mode("o_mode", mode, decode_mode(cfg_now));
	endtask

	task automatic feed_sample(input logic [ADC_W-1:0] s);
		@(negedge clk_sys);
		adc_valid  = 1'b1;
		adc_sample = s;
		model_slice(s);
		@(negedge clk_sys);
		adc_valid = 1'b0;
		@(negedge clk_sys);
		check_bit("o_core_tape (slicer)", core_tape, model_bit);   // 2 cycles after strobe
		@(negedge clk_sys);
	endtask

	////////////////////
	// Tests
	task automatic test_registers();
		logic [WB_DW-1:0] rdat;
		cfg_t             probe;
		reg_read(REG_CFG, rdat);
		check_cfg("cfg after reset", cfg_t'(rdat[CFG_W-1:0]), '0);
		reg_read(REG_STAT, rdat);
		check_bit("stat tape bit", rdat[0], 1'b0);
		check_bit("stat core reset", rdat[1], 1'b0);
		// Router fields only, no reset sequence
		cfg_now.tape_from_adc = 1'b1;
		cfg_now.tape_monitor  = 1'b1;
		cfg_now.joy_swap      = 1'b1;
		reg_write(REG_CFG, WB_DW'(cfg_now), 4'b0001);
		reg_read(REG_CFG, rdat);
		check_cfg("cfg readback", cfg_t'(rdat[CFG_W-1:0]), cfg_now);
		check_bit("cfg upper bits", |rdat[WB_DW-1:CFG_W], 1'b0);
		probe         = cfg_now;
		probe.machine = DRAGON64;
		probe.joy_swap = 1'b0;
		reg_write(REG_CFG, WB_DW'(probe), 4'b1110);     // Lane 0 off
		reg_read(REG_CFG, rdat);
		check_cfg("cfg after masked write", cfg_t'(rdat[CFG_W-1:0]), cfg_now);
		reg_write(REG_STAT, 32'hFFFF_FFFF, 4'hF);       // Read only
		reg_read(REG_CFG, rdat);
		check_cfg("cfg after status write", cfg_t'(rdat[CFG_W-1:0]), cfg_now);
		check_bit("o_core_reset", core_reset, 1'b0);
	endtask

	task automatic test_machine();
		logic [WB_DW-1:0] rdat;
		for (int m = 1; m <= 4; m++)
		begin
			cfg_now.machine = machine_t'(2'(m % 4));     // 1, 2, 3, then back to 0
			reg_write(REG_CFG, WB_DW'(cfg_now), 4'hF);
			watch_reset();
		end
		cfg_now.hard_toggle = ~cfg_now.hard_toggle;
		reg_write(REG_CFG, WB_DW'(cfg_now), 4'hF);
		watch_reset();
		cfg_now.disk_cart = 1'b1;
		reg_write(REG_CFG, WB_DW'(cfg_now), 4'hF);
		watch_reset();
		// Soft reset holds the core
		cfg_now.soft_reset = 1'b1;
		reg_write(REG_CFG, WB_DW'(cfg_now), 4'hF);
		repeat (3)
		begin
			check_bit("o_core_reset (soft)", core_reset, 1'b1);
			check_bit("o_hard_reset (soft)", hard_reset, 1'b0);
			@(negedge clk_sys);
		end
		reg_read(REG_STAT, rdat);
		check_bit("stat core reset", rdat[1], 1'b1);
		cfg_now.soft_reset = 1'b0;
		reg_write(REG_CFG, WB_DW'(cfg_now), 4'hF);
		check_bit("o_core_reset (soft off)", core_reset, 1'b0);
	endtask

	task automatic test_slicer();
		logic [31:0]      r;
		logic [ADC_W-1:0] s;
		logic [WB_DW-1:0] rdat;
		logic [1:0]       lvl;
		logic [ADC_W-1:0] levels [4];
		levels = '{12'h0C0, 12'hE40, 12'h7D0, 12'h860};
		cfg_now.tape_from_adc = 1'b1;                     // Slicer bit on o_core_tape
		reg_write(REG_CFG, WB_DW'(cfg_now), 4'hF);
		for (int n = 0; n < N_RANDOM + N_STEPPED; n++)
		begin
			if (n < N_RANDOM)
			begin
				r = next_rand();
				s = r[ADC_W-1:0];
			end
			else
			begin
				lvl = 2'((n - N_RANDOM) / 40);            // Step every 40 samples
				s   = levels[lvl];
			end
			feed_sample(s);
			if (n % STAT_EVERY == STAT_EVERY - 1)
			begin
				reg_read(REG_STAT, rdat);
				check_bit("stat tape bit", rdat[0], model_bit);
			end
		end
	endtask

	task automatic test_tape_audio();
		logic [31:0] r;
		logic        tape;
		for (int mode_sel = 0; mode_sel < 4; mode_sel++)
		begin
			cfg_now.tape_from_adc = mode_sel[0];
			cfg_now.tape_monitor  = mode_sel[1];
			reg_write(REG_CFG, WB_DW'(cfg_now), 4'hF);
			repeat (4)
			begin
				r = next_rand();
				@(negedge clk_sys);
				player_bit  = r[31];
				core_sndout = r[30];
				core_sound  = r[ADC_W-1:0];
				@(posedge clk_sys);
				tape = cfg_now.tape_from_adc ? model_bit : player_bit;
				check_bit("o_core_tape", core_tape, tape);
				check_audio("o_audio", audio, mix_audio(cfg_now, tape, core_sndout, core_sound));
			end
		end
	endtask

	task automatic test_joysticks();
		logic [31:0] r;
		for (int swap = 0; swap < 2; swap++)
		begin
			cfg_now.joy_swap = swap[0];
			reg_write(REG_CFG, WB_DW'(cfg_now), 4'hF);
			repeat (4)
			begin
				@(negedge clk_sys);
				joy1_in  = next_rand();
				joy2_in  = next_rand();
				r        = next_rand();
				ajoy1_in = ajoy_t'(r[15:0]);
				ajoy2_in = ajoy_t'(r[31:16]);
				@(posedge clk_sys);
				check_joy("o_joy1", joy1_out, (swap != 0) ? joy2_in : joy1_in);
				check_joy("o_joy2", joy2_out, (swap != 0) ? joy1_in : joy2_in);
				check_ajoy("o_ajoy1", ajoy1_out, recenter((swap != 0) ? ajoy2_in : ajoy1_in));
				check_ajoy("o_ajoy2", ajoy2_out, recenter((swap != 0) ? ajoy1_in : ajoy2_in));
			end
		end
	endtask

	////////////////////
	// Main sequence
	initial
	begin
		errors      = 0;
		checks      = 0;
		cycle_cnt   = 0;
		rng_state   = 32'hfb76;
		cfg_now     = '0;
		model_ptr   = '0;
		model_total = 0;
		model_bit   = 1'b0;
		foreach (model_win[i])
			model_win[i] = '0;
		clk_sys     = 1'b0;
		arst_n      = 1'b0;
		wb_req      = '0;
		adc_valid   = 1'b0;
		adc_sample  = '0;
		player_bit  = 1'b0;
		core_sndout = 1'b0;
		core_sound  = '0;
		joy1_in     = '0;
		joy2_in     = '0;
		ajoy1_in    = '0;
		ajoy2_in    = '0;
		repeat (5) @(negedge clk_sys);
		arst_n = 1'b1;

		test_registers();
		test_machine();
		test_slicer();
		test_tape_audio();
		test_joysticks();

		repeat (2) @(negedge clk_sys);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* coco_glue.f */
logic/coco_glue_pkg.sv
logic/wb_config_regs.sv
logic/machine_reset_seq.sv
logic/adc_tape_slicer.sv
logic/peripheral_router.sv
logic/coco_glue.sv
sim/coco_glue_chk.sv
sim/coco_glue_tb.sv

/* Makefile */
# Verilator build and run for the CoCo2 / Dragon glue testbench

TOP := coco_glue_tb

all: run

obj_dir/V$(TOP): coco_glue.f $(wildcard logic/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f coco_glue.f

run: obj_dir/V$(TOP)
	-obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
